//--- conv_cfg_pkg.sv
package conv_cfg_pkg;

  ////////////////////////////////////////
  // line buffer word geometry
  ////////////////////////////////////////

  // log2 of the pixels held in one buffer word row
  localparam int pixels_in_row_2pow = 5;

  // log2 of the input channels packed into one bank word
  // two 16-bit half-words per 32-bit word
  localparam int ifs_in_row_2pow = 1;

  ////////////////////////////////////////
  // default depths and limits
  ////////////////////////////////////////

  // input line buffer bank depth as log2 (4096 words)
  localparam int input_buffer_size_2pow = 12;

  // slab buffer depth as log2 (8192 words)
  localparam int slab_buffer_size_2pow = 13;

  // largest kernel height the sequencer may walk
  localparam int kernel_rows_max = 11;

endpackage

//--- conv_row_fetch.f
conv_cfg_pkg.sv
row_addr_pkg.sv
row_request_gen.sv
row_addr_translator.sv
row_fetch.sv
conv_row_fetch_top.sv
conv_row_fetch_tb.sv

//--- conv_row_fetch_patterns.txt
// kind 1 config: s p nif_2pow ix_2pow iy | kind 2 load: bank adr data
// kind 3 start: k_rows poy iy_start row_base_in_3s row_start_idx if_start slab_num
// kind 4 result: pix_data slab_rd_adr slab_wr_en slab_wr_adr slab_wr_idx
1 1 1 2 5 8 0 0
2 1 0 1a2b1c3d 0 0 0 0
2 1 2 12340001 0 0 0 0
2 2 2 22340002 0 0 0 0
2 3 2 32340003 0 0 0 0
2 1 5 15550155 0 0 0 0
2 2 5 25550255 0 0 0 0
2 1 4 14440144 0 0 0 0
// stride 1, two rows above the top padding, then input row 1
3 3 1 0 0 0 1 1
4 0 0 0 ffff 0 0 0
4 0 0 0 ffff 0 0 0
4 1c3d 0 1 0 1 0 0
// bias 0 or less falls back to base 0, upper half, no slab read
3 3 1 2 1 20 2 0
4 1234 ffff 1 5 1 0 0
4 2234 ffff 1 5 2 0 0
4 3234 ffff 1 5 3 0 0
// last two input rows, then one below the bottom
3 3 2 8 1 0 3 2
4 155 a 1 a 1 0 0
4 255 a 1 a 2 0 0
4 0 2 0 ffff 0 0 0
3 1 0 3 0 0 1 1
4 0 0 0 ffff 0 0 0
// stride 2 with padding 2, base 1 at its boundary
1 2 2 2 5 8 0 0
3 3 1 4 1 0 1 1
4 2 4 1 4 2 0 0
4 3 4 1 4 3 0 0
4 144 8 1 8 1 0 0

//--- conv_row_fetch_tb.sv
`timescale 1ns/1ps

module conv_row_fetch_tb;
  import row_addr_pkg::*;

  localparam int max_lines      = 64;
  localparam int words_per_line = 8;
  localparam int clk_period     = 40;

  logic       clk;
  logic       reset;
  logic [3:0] cfg_s, cfg_p, cfg_nif_2pow, cfg_ix_2pow;
  row_idx_t   cfg_iy;
  logic       start;
  logic [3:0] k_rows;
  adr_t       poy_in, iy_start_in, row_base_in_3s_in, row_start_idx_in, if_start_in;
  logic [3:0] slab_num_in;
  logic       load_en;
  buf_idx_t   load_bank;
  adr_t       load_adr;
  bank_word_t load_data;
  logic       done, pix_valid, slab_wr_en;
  pix_word_t  pix_data;
  adr_t       slab_rd_adr, slab_wr_adr;
  buf_idx_t   slab_wr_idx;

  // one pattern line = kind word + 7 field words
  logic [31:0] pat [0:max_lines*words_per_line-1];
  int          n_lines = 0;
  int          starts_sent = 0;
  int          done_seen = 0;
  logic        idle_watch;

  conv_row_fetch_top #(
    .input_buffer_size_2pow(conv_cfg_pkg::input_buffer_size_2pow),
    .slab_buffer_size_2pow (conv_cfg_pkg::slab_buffer_size_2pow),
    .kernel_rows_max       (conv_cfg_pkg::kernel_rows_max)
  ) u_dut (
    .clk, .reset, .cfg_s, .cfg_p, .cfg_nif_2pow, .cfg_ix_2pow, .cfg_iy,
    .start, .k_rows, .poy_in, .iy_start_in, .row_base_in_3s_in, .row_start_idx_in,
    .if_start_in, .slab_num_in, .load_en, .load_bank, .load_adr, .load_data,
    .done, .pix_valid, .pix_data, .slab_rd_adr, .slab_wr_en, .slab_wr_adr, .slab_wr_idx
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // failure reporting and compare
  ////////////////////////////////////////

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t ns: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // stimulus from pattern lines
  ////////////////////////////////////////

  // geometry is only taken while reset is high
  task automatic apply_config(input int b);
    @(negedge clk);
    reset        = 1'b1;
    idle_watch   = 1'b0;
    cfg_s        = pat[b+1][3:0];
    cfg_p        = pat[b+2][3:0];
    cfg_nif_2pow = pat[b+3][3:0];
    cfg_ix_2pow  = pat[b+4][3:0];
    cfg_iy       = pat[b+5][15:0];
    repeat (8) @(negedge clk);
    reset      = 1'b0;
    idle_watch = 1'b1;
  endtask

  task automatic load_bank_word(input int b);
    @(negedge clk);
    load_en   = 1'b1;
    load_bank = pat[b+1][1:0];
    load_adr  = pat[b+2][15:0];
    load_data = pat[b+3];
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // random idle gap, then a one-cycle start pulse
  task automatic drive_start(input int b);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    @(negedge clk);
    start             = 1'b1;
    idle_watch        = 1'b0;
    k_rows            = pat[b+1][3:0];
    poy_in            = pat[b+2][15:0];
    iy_start_in       = pat[b+3][15:0];
    row_base_in_3s_in = pat[b+4][15:0];
    row_start_idx_in  = pat[b+5][15:0];
    if_start_in       = pat[b+6][15:0];
    slab_num_in       = pat[b+7][3:0];
    starts_sent++;
    @(negedge clk);
    start = 1'b0;
  endtask

  ////////////////////////////////////////
  // monitors
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset && done) begin
      done_seen++;
    end
    // quiet outputs between reset and the first start
    if (idle_watch) begin
      compare_value(32'(pix_valid), 32'd0, "pix_valid before start");
      compare_value(32'(slab_wr_en), 32'd0, "slab_wr_en before start");
      compare_value(32'(done), 32'd0, "done before start");
    end
  end

  // time budget grows with the pattern file
  initial begin
    wait (n_lines > 0);
    repeat (n_lines * 20 + 100) @(posedge clk);
    stop_run("watchdog expired before all pattern lines were handled");
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int i;
    int b;
    int pending;
    int res_n;
    int cyc;
    reset             = 1'b1;
    cfg_s             = '0;
    cfg_p             = '0;
    cfg_nif_2pow      = '0;
    cfg_ix_2pow       = '0;
    cfg_iy            = '0;
    start             = 1'b0;
    k_rows            = '0;
    poy_in            = '0;
    iy_start_in       = '0;
    row_base_in_3s_in = '0;
    row_start_idx_in  = '0;
    if_start_in       = '0;
    slab_num_in       = '0;
    load_en           = 1'b0;
    load_bank         = '0;
    load_adr          = '0;
    load_data         = '0;
    idle_watch        = 1'b0;
    void'($urandom(32'hb680_8631));
    for (i = 0; i < max_lines * words_per_line; i++) begin
      pat[i] = '0;
    end
    $readmemh("conv_row_fetch_patterns.txt", pat);
    // kind 0 marks the end of the file
    while (n_lines < max_lines && pat[n_lines * words_per_line] != 0) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      stop_run("pattern file is empty or missing");
    end
    pending = 0;
    res_n   = 0;
    cyc     = 0;
    for (i = 0; i < n_lines; i++) begin
      b = i * words_per_line;
      case (pat[b])
        32'd1: apply_config(b);
        32'd2: load_bank_word(b);
        32'd3: begin
          if (pending != 0) begin
            stop_run("start line came before all results of the previous start");
          end
          drive_start(b);
          pending = int'(pat[b+1][3:0]);
          res_n   = 0;
          // one rising edge already seen the start
          cyc     = 1;
        end
        32'd4: begin
          if (pending == 0) begin
            stop_run("result line without a start before it");
          end
          while (!pix_valid) begin
            @(negedge clk);
            cyc++;
            if (cyc > 20) begin
              stop_run("timeout waiting for pix_valid");
            end
          end
          // first row 5 cycles after start, then one per cycle
          compare_value(32'(cyc), 32'(5 + res_n), "result latency");
          compare_value(32'(pix_data), pat[b+1], "pix_data");
          compare_value(32'(slab_rd_adr), pat[b+2], "slab_rd_adr");
          compare_value(32'(slab_wr_en), pat[b+3], "slab_wr_en");
          compare_value(32'(slab_wr_adr), pat[b+4], "slab_wr_adr");
          compare_value(32'(slab_wr_idx), pat[b+5], "slab_wr_idx");
          @(negedge clk);
          cyc++;
          res_n++;
          pending--;
          if (pending == 0) begin
            compare_value(32'(pix_valid), 32'd0, "pix_valid after last row");
            compare_value(32'(done_seen), 32'(starts_sent), "done pulse count");
          end
        end
        default: stop_run("unknown line kind in pattern file");
      endcase
    end
    if (pending != 0) begin
      stop_run("pattern file ends before all results of a start");
    end
    repeat (2) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- conv_row_fetch_top.sv
`timescale 1ns/1ps

module conv_row_fetch_top #(
  parameter int input_buffer_size_2pow = conv_cfg_pkg::input_buffer_size_2pow,
  parameter int slab_buffer_size_2pow  = conv_cfg_pkg::slab_buffer_size_2pow,
  parameter int kernel_rows_max        = conv_cfg_pkg::kernel_rows_max
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [3:0]               cfg_s,
  input  logic [3:0]               cfg_p,
  input  logic [3:0]               cfg_nif_2pow,
  input  logic [3:0]               cfg_ix_2pow,
  input  row_addr_pkg::row_idx_t   cfg_iy,
  input  logic                     start,
  input  logic [3:0]               k_rows,
  input  row_addr_pkg::adr_t       poy_in,
  input  row_addr_pkg::adr_t       iy_start_in,
  input  row_addr_pkg::adr_t       row_base_in_3s_in,
  input  row_addr_pkg::adr_t       row_start_idx_in,
  input  row_addr_pkg::adr_t       if_start_in,
  input  logic [3:0]               slab_num_in,
  input  logic                     load_en,
  input  row_addr_pkg::buf_idx_t   load_bank,
  input  row_addr_pkg::adr_t       load_adr,
  input  row_addr_pkg::bank_word_t load_data,
  output logic                     done,
  output logic                     pix_valid,
  output row_addr_pkg::pix_word_t  pix_data,
  output row_addr_pkg::adr_t       slab_rd_adr,
  output logic                     slab_wr_en,
  output row_addr_pkg::adr_t       slab_wr_adr,
  output row_addr_pkg::buf_idx_t   slab_wr_idx
);
  import row_addr_pkg::*;

  // sequencer to translator
  logic       req_valid;
  adr_t       poy, ky, iy_start, row_base_in_3s, row_start_idx, if_start;
  logic [3:0] slab_num;

  // translator to fetch
  logic     row_valid, word_select;
  row_idx_t row_idx;
  buf_idx_t buf_idx, slab_idx_to_wr;
  adr_t     buf_adr, slab_adr, slab_adr_to_wr;

  row_request_gen #(
    .kernel_rows_max(kernel_rows_max)
  ) u_req_gen (
    .clk, .reset, .start, .k_rows, .poy_in, .iy_start_in, .row_base_in_3s_in,
    .row_start_idx_in, .if_start_in, .slab_num_in, .req_valid, .done, .poy, .ky,
    .iy_start, .row_base_in_3s, .row_start_idx, .if_start, .slab_num
  );

  // slab_idx is for the slab read side, which lives outside this path
  row_addr_translator #(
    .input_buffer_size_2pow(input_buffer_size_2pow),
    .slab_buffer_size_2pow (slab_buffer_size_2pow)
  ) u_translator (
    .clk, .reset, .cfg_s, .cfg_p, .cfg_nif_2pow, .cfg_ix_2pow, .cfg_iy,
    .req_valid, .poy, .ky, .iy_start, .row_base_in_3s, .row_start_idx, .if_start,
    .slab_num, .row_valid, .row_idx, .buf_idx, .buf_adr, .word_select, .slab_adr,
    .slab_idx(), .slab_adr_to_wr, .slab_idx_to_wr
  );

  row_fetch #(
    .input_buffer_size_2pow(input_buffer_size_2pow)
  ) u_fetch (
    .clk, .reset, .load_en, .load_bank, .load_adr, .load_data, .row_valid, .row_idx,
    .buf_idx, .buf_adr, .word_select, .slab_adr, .slab_adr_to_wr, .slab_idx_to_wr,
    .pix_valid, .pix_data, .slab_rd_adr, .slab_wr_en, .slab_wr_adr, .slab_wr_idx
  );

endmodule

//--- row_addr_pkg.sv
package row_addr_pkg;

  // buffer or slab word address
  typedef logic [15:0] adr_t;

  // input row index, 1-based once the padding is removed
  typedef logic [15:0] row_idx_t;

  // rotating line buffer select
  // 1..3 pick a bank, 0 means no bank
  typedef logic [1:0] buf_idx_t;

  // one pixel half-word as handed to the mac side
  typedef logic [15:0] pix_word_t;

  // one full bank word, two half-words side by side
  typedef logic [31:0] bank_word_t;

  // marker for padding rows and absent slab reads
  localparam adr_t row_invalid = 16'hffff;

endpackage

//--- row_addr_translator.sv
`timescale 1ns/1ps

module row_addr_translator #(
  parameter int input_buffer_size_2pow = conv_cfg_pkg::input_buffer_size_2pow,
  parameter int slab_buffer_size_2pow  = conv_cfg_pkg::slab_buffer_size_2pow
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [3:0]             cfg_s,
  input  logic [3:0]             cfg_p,
  input  logic [3:0]             cfg_nif_2pow,
  input  logic [3:0]             cfg_ix_2pow,
  input  row_addr_pkg::row_idx_t cfg_iy,
  input  logic                   req_valid,
  input  row_addr_pkg::adr_t     poy,
  input  row_addr_pkg::adr_t     ky,
  input  row_addr_pkg::adr_t     iy_start,
  input  row_addr_pkg::adr_t     row_base_in_3s,
  input  row_addr_pkg::adr_t     row_start_idx,
  input  row_addr_pkg::adr_t     if_start,
  input  logic [3:0]             slab_num,
  output logic                   row_valid,
  output row_addr_pkg::row_idx_t row_idx,
  output row_addr_pkg::buf_idx_t buf_idx,
  output row_addr_pkg::adr_t     buf_adr,
  output logic                   word_select,
  output row_addr_pkg::adr_t     slab_adr,
  output row_addr_pkg::buf_idx_t slab_idx,
  output row_addr_pkg::adr_t     slab_adr_to_wr,
  output row_addr_pkg::buf_idx_t slab_idx_to_wr
);
  import conv_cfg_pkg::*;
  import row_addr_pkg::*;

  ////////////////////////////////////////
  // geometry, captured while reset is high
  ////////////////////////////////////////

  logic [3:0] s_q, p_q, nif_q, chan_sh_q;
  row_idx_t   iy_q;
  adr_t       s3_q, mask_in_q, mask_slab_q;
  logic [4:0] in_sh_q, slab_sh_q;
  logic [4:0] in_sh_n, slab_sh_n;

  // row word size exponents for the input bank and the slab
  assign in_sh_n   = 5'(cfg_nif_2pow + cfg_ix_2pow - ifs_in_row_2pow - pixels_in_row_2pow);
  assign slab_sh_n = 5'(cfg_nif_2pow + cfg_ix_2pow - pixels_in_row_2pow);

  always_ff @(posedge clk) begin
    if (reset) begin
      s_q         <= cfg_s;
      s3_q        <= {12'b0, cfg_s} + {11'b0, cfg_s, 1'b0};
      p_q         <= cfg_p;
      iy_q        <= cfg_iy;
      nif_q       <= cfg_nif_2pow;
      chan_sh_q   <= 4'(cfg_nif_2pow - ifs_in_row_2pow);
      in_sh_q     <= in_sh_n;
      slab_sh_q   <= slab_sh_n;
      // rows that fit = depth exponent minus row size exponent
      mask_in_q   <= adr_t'(32'hffff >> (16 - (input_buffer_size_2pow - int'(in_sh_n))));
      mask_slab_q <= adr_t'(32'hffff >> (16 - (slab_buffer_size_2pow - int'(slab_sh_n))));
    end
  end

  ////////////////////////////////////////
  // stage 1 row index and bias
  ////////////////////////////////////////

  adr_t t_w, p_ext, base3_w, bias0_w;
  logic step_down;

  assign t_w       = ky + iy_start;
  assign p_ext     = {12'b0, p_q};
  assign base3_w   = row_base_in_3s + (row_base_in_3s << 1);
  assign bias0_w   = t_w - p_ext - base3_w;
  // bias of 0 or less belongs to the previous group of 3s rows
  assign step_down = (t_w <= p_ext + base3_w);

  logic     valid_s1, valid_s2;
  row_idx_t row_idx_s1, row_idx_s2;
  adr_t     bias_s1, base_s1;
  adr_t     row_start_idx_s1, row_start_idx_s2;
  adr_t     if_start_s1, if_start_s2;
  logic [3:0] slab_num_s1, slab_num_s2;

  always_ff @(posedge clk) begin
    // poy 0 and rows outside the top or bottom padding are absent
    if (poy == '0 || t_w < p_ext + 16'd1 || t_w > p_ext + iy_q) begin
      row_idx_s1 <= row_invalid;
    end else begin
      row_idx_s1 <= t_w - p_ext;
    end
    bias_s1          <= step_down ? bias0_w + s3_q : bias0_w;
    base_s1          <= step_down ? row_base_in_3s - 16'd1 : row_base_in_3s;
    row_start_idx_s1 <= row_start_idx;
    if_start_s1      <= if_start;
    slab_num_s1      <= slab_num;
  end

  ////////////////////////////////////////
  // stage 2 bank and row-in-buffer
  ////////////////////////////////////////

  buf_idx_t   red_idx, idx_s2;
  logic [1:0] red_off;
  adr_t       pos_n, pos_s2;
  logic       invalid_s1, invalid_s2;

  assign invalid_s1 = (row_idx_s1 == row_invalid);

  // bias 1..12 folds onto banks 1..3, one word row per fold
  always_comb begin
    if (bias_s1 <= 16'd3) begin
      red_idx = bias_s1[1:0];
      red_off = 2'd0;
    end else if (bias_s1 <= 16'd6) begin
      red_idx = 2'(bias_s1 - 16'd3);
      red_off = 2'd1;
    end else if (bias_s1 <= 16'd9) begin
      red_idx = 2'(bias_s1 - 16'd6);
      red_off = 2'd2;
    end else begin
      red_idx = 2'(bias_s1 - 16'd9);
      red_off = 2'd3;
    end
    case (s_q)
      4'd1:    pos_n = base_s1 + {14'b0, red_off};
      4'd2:    pos_n = (base_s1 << 1) + {14'b0, red_off};
      default: pos_n = {14'b0, red_off};
    endcase
  end

  always_ff @(posedge clk) begin
    row_idx_s2       <= row_idx_s1;
    idx_s2           <= (valid_s1 && !invalid_s1) ? red_idx : 2'd0;
    pos_s2           <= invalid_s1 ? '0 : pos_n;
    row_start_idx_s2 <= row_start_idx_s1;
    if_start_s2      <= if_start_s1;
    slab_num_s2      <= slab_num_s1;
  end

  ////////////////////////////////////////
  // stage 3 addresses
  ////////////////////////////////////////

  adr_t if_m1_w, buf_sum, slab_sum;

  assign invalid_s2 = (row_idx_s2 == row_invalid);
  assign if_m1_w    = if_start_s2 - 16'd1;
  // row part + column start part + channel word part
  assign buf_sum  = ((pos_s2 & mask_in_q) << in_sh_q)
                  + ((row_start_idx_s2 << chan_sh_q) >> pixels_in_row_2pow)
                  + (if_m1_w >> ifs_in_row_2pow);
  // slab holds one channel per word
  assign slab_sum = ((pos_s2 & mask_slab_q) << slab_sh_q)
                  + ((row_start_idx_s2 << nif_q) >> pixels_in_row_2pow)
                  + if_m1_w;

  always_ff @(posedge clk) begin
    row_idx        <= row_idx_s2;
    buf_adr        <= invalid_s2 ? row_invalid : buf_sum;
    word_select    <= if_m1_w[0];
    slab_adr       <= (slab_num_s2 == 4'd0) ? row_invalid : slab_sum;
    slab_adr_to_wr <= invalid_s2 ? row_invalid : slab_sum;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1       <= 1'b0;
      valid_s2       <= 1'b0;
      row_valid      <= 1'b0;
      buf_idx        <= '0;
      slab_idx       <= '0;
      slab_idx_to_wr <= '0;
    end else begin
      valid_s1       <= req_valid;
      valid_s2       <= valid_s1;
      row_valid      <= valid_s2;
      buf_idx        <= idx_s2;
      slab_idx       <= (slab_num_s2 == 4'd0) ? 2'd0 : idx_s2;
      slab_idx_to_wr <= idx_s2;
    end
  end

  // a real row always lands in one of the three banks
  ap_bank_sel : assert property (
    @(posedge clk) disable iff (reset)
    (row_valid && row_idx != row_invalid) |-> (buf_idx != 2'd0)
  ) else $error("row %0d has no bank", row_idx);

endmodule

//--- row_fetch.sv
`timescale 1ns/1ps

module row_fetch #(
  parameter int input_buffer_size_2pow = conv_cfg_pkg::input_buffer_size_2pow
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load_en,
  input  row_addr_pkg::buf_idx_t   load_bank,
  input  row_addr_pkg::adr_t       load_adr,
  input  row_addr_pkg::bank_word_t load_data,
  input  logic                     row_valid,
  input  row_addr_pkg::row_idx_t   row_idx,
  input  row_addr_pkg::buf_idx_t   buf_idx,
  input  row_addr_pkg::adr_t       buf_adr,
  input  logic                     word_select,
  input  row_addr_pkg::adr_t       slab_adr,
  input  row_addr_pkg::adr_t       slab_adr_to_wr,
  input  row_addr_pkg::buf_idx_t   slab_idx_to_wr,
  output logic                     pix_valid,
  output row_addr_pkg::pix_word_t  pix_data,
  output row_addr_pkg::adr_t       slab_rd_adr,
  output logic                     slab_wr_en,
  output row_addr_pkg::adr_t       slab_wr_adr,
  output row_addr_pkg::buf_idx_t   slab_wr_idx
);
  import row_addr_pkg::*;

  localparam int depth = 2 ** input_buffer_size_2pow;

  ////////////////////////////////////////
  // three rotating input banks
  ////////////////////////////////////////

  bank_word_t banks [1:3][0:depth-1];
  bank_word_t rd_word_q;
  logic       sel_q, pad_q;

  always_ff @(posedge clk) begin
    if (load_en && load_bank != 2'd0) begin
      banks[load_bank][load_adr[input_buffer_size_2pow-1:0]] <= load_data;
    end
  end

  // one-cycle registered read, padding rows skip the bank
  always_ff @(posedge clk) begin
    if (row_valid && buf_idx != 2'd0) begin
      rd_word_q <= banks[buf_idx][buf_adr[input_buffer_size_2pow-1:0]];
    end
    sel_q       <= word_select;
    pad_q       <= (row_idx == row_invalid) || (buf_idx == 2'd0);
    slab_rd_adr <= slab_adr;
    slab_wr_adr <= slab_adr_to_wr;
  end

  // upper half for select 1
  assign pix_data = pad_q ? '0 : (sel_q ? rd_word_q[31:16] : rd_word_q[15:0]);

  ////////////////////////////////////////
  // strobes toward mac and slab
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid   <= 1'b0;
      slab_wr_en  <= 1'b0;
      slab_wr_idx <= '0;
    end else begin
      pix_valid   <= row_valid;
      // only real rows get written into the slab
      slab_wr_en  <= row_valid && (row_idx != row_invalid);
      slab_wr_idx <= slab_idx_to_wr;
    end
  end

  // the outside loader must always name a bank
  ap_load_bank : assert property (
    @(posedge clk) disable iff (reset)
    load_en |-> (load_bank != 2'd0)
  ) else $error("load into bank 0 at adr %0h", load_adr);

endmodule

//--- row_request_gen.sv
`timescale 1ns/1ps

module row_request_gen #(
  parameter int kernel_rows_max = conv_cfg_pkg::kernel_rows_max
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic [3:0]         k_rows,
  input  row_addr_pkg::adr_t poy_in,
  input  row_addr_pkg::adr_t iy_start_in,
  input  row_addr_pkg::adr_t row_base_in_3s_in,
  input  row_addr_pkg::adr_t row_start_idx_in,
  input  row_addr_pkg::adr_t if_start_in,
  input  logic [3:0]         slab_num_in,
  output logic               req_valid,
  output logic               done,
  output row_addr_pkg::adr_t poy,
  output row_addr_pkg::adr_t ky,
  output row_addr_pkg::adr_t iy_start,
  output row_addr_pkg::adr_t row_base_in_3s,
  output row_addr_pkg::adr_t row_start_idx,
  output row_addr_pkg::adr_t if_start,
  output logic [3:0]         slab_num
);
  import row_addr_pkg::*;

  // last kernel row of the current output row
  logic [3:0] k_last;

  ////////////////////////////////////////
  // kernel row walk
  ////////////////////////////////////////

  // req_valid doubles as the busy flag
  // so a start during a walk falls through untouched
  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
      done      <= 1'b0;
      ky        <= '0;
      k_last    <= '0;
    end else if (req_valid) begin
      if (ky == adr_t'(k_last)) begin
        // walk finished, back to idle
        req_valid <= 1'b0;
        done      <= 1'b0;
      end else begin
        ky   <= ky + 16'd1;
        // done rides along with the last request
        done <= (ky + 16'd1 == adr_t'(k_last));
      end
    end else begin
      done <= 1'b0;
      // zero kernel rows gives nothing to walk
      if (start && k_rows != 4'd0) begin
        req_valid <= 1'b1;
        ky        <= '0;
        k_last    <= k_rows - 4'd1;
        done      <= (k_rows == 4'd1);
      end
    end
  end

  ////////////////////////////////////////
  // output row fields
  ////////////////////////////////////////

  // held for the whole walk
  always_ff @(posedge clk) begin
    if (start && !req_valid) begin
      poy            <= poy_in;
      iy_start       <= iy_start_in;
      row_base_in_3s <= row_base_in_3s_in;
      row_start_idx  <= row_start_idx_in;
      if_start       <= if_start_in;
      slab_num       <= slab_num_in;
    end
  end

  // ky never runs past the kernel height the array supports
  ap_ky_range : assert property (
    @(posedge clk) disable iff (reset)
    req_valid |-> (ky < adr_t'(kernel_rows_max))
  ) else $error("ky %0d beyond kernel_rows_max", ky);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the row fetch testbench with verilator, run it, judge the log
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module conv_row_fetch_tb -f conv_row_fetch.f -o conv_row_fetch_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/conv_row_fetch_sim > sim.log 2>&1 || echo "simulator returned nonzero"
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "run finished cleanly"
